// File: verilog/sp_fetch_pkg.sv
package sp_fetch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and word widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [15:0] vram_word;       // One VRAM data word
	typedef logic [23:0] vram_addr;       // VRAM word address
	typedef logic [22:0] vram_insn_addr;  // Address in units of 32-bit instructions
	typedef logic [31:0] insn_word;       // Instruction or header word
	typedef logic [31:0] cmd_word;        // Entry count and batch length

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program header and fetch FIFO geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int insn_subword_bits = 1;  // Header address fields start above this
	localparam int insn_entry_size = 4;    // Code base, code length, batch base, batch length
	localparam int fetch_fifo_depth = 8;

	localparam int fifo_ptr_bits = $clog2(fetch_fifo_depth);
	localparam int entry_ptr_bits = $clog2(insn_entry_size);

	typedef logic [fifo_ptr_bits-1:0] fifo_ptr;
	typedef logic [fifo_ptr_bits:0]   fifo_count;  // Holds 0 up to the full depth
	typedef logic [entry_ptr_bits-1:0] entry_ptr;

	typedef enum logic [1:0] {
		idle,
		header,
		loop,
		flush
	} fetch_state;

	// Clear-lanes flag sits in the top bit
	typedef logic [$bits(insn_word):0] fifo_entry;

endpackage

// File: verilog/insn_bus_if.sv
`timescale 1ns/10ps

interface insn_bus_if import sp_fetch_pkg::*; ();

	logic          read;
	vram_insn_addr address;
	insn_word      readdata;
	logic          waitrequest;
	logic          readdatavalid;

	modport master (
		output read,
		output address,
		input  readdata,
		input  waitrequest,
		input  readdatavalid
	);

	modport slave (
		input  read,
		input  address,
		output readdata,
		output waitrequest,
		output readdatavalid
	);

endinterface

// File: verilog/sp_widener.sv
`timescale 1ns/10ps

module sp_widener import sp_fetch_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	insn_bus_if.slave bus,
	output logic     word_read,
	output vram_addr word_address,
	input  vram_word word_readdata,
	input  logic     word_waitrequest,
	input  logic     word_readdatavalid
);

	logic     req_odd;      // Next word read goes to the odd half
	logic     resp_odd;     // Next answer is the high half
	logic     word_accept;
	logic     wide_valid;
	insn_word wide_data;
	vram_word low_half;

	assign word_read = bus.read;
	assign word_address = {bus.address, req_odd};  // Even word holds the low half
	assign word_accept = word_read && !word_waitrequest;

	// The instruction is only taken once its odd word is taken
	assign bus.waitrequest = !(req_odd && word_accept);
	assign bus.readdata = wide_data;
	assign bus.readdatavalid = wide_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request and answer phase tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_odd <= 1'b0;
			resp_odd <= 1'b0;
			wide_valid <= 1'b0;
		end else begin
			if (word_accept)
				req_odd <= !req_odd;

			if (word_readdatavalid)
				resp_odd <= !resp_odd;

			wide_valid <= word_readdatavalid && resp_odd;  // One cycle after the high half
		end
	end

	always_ff @(posedge clk) begin
		if (word_readdatavalid && !resp_odd)
			low_half <= word_readdata;

		if (word_readdatavalid && resp_odd)
			wide_data <= {word_readdata, low_half};
	end

endmodule

// File: verilog/insn_fifo.sv
`timescale 1ns/10ps

module insn_fifo import sp_fetch_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  fifo_entry in,
	input  logic      in_valid,
	output fifo_entry out,
	output logic      out_valid,
	input  logic      out_ready,
	output logic      empty
);

	fifo_entry mem [fetch_fifo_depth];
	fifo_ptr   wr_ptr;
	fifo_ptr   rd_ptr;
	fifo_count count;
	logic      pop;

	function automatic fifo_ptr next_ptr(fifo_ptr ptr);
		return (ptr == fifo_ptr'(fetch_fifo_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = count == '0;
	assign out_valid = !empty;
	assign out = mem[rd_ptr];            // Head stays put until it is popped
	assign pop = out_valid && out_ready;

	// Writes are never refused; the fetcher's credit tracker keeps room
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);

			if (pop)
				rd_ptr <= next_ptr(rd_ptr);

			case ({in_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= in;
	end

endmodule

// File: verilog/fifo_overflow.sv
`timescale 1ns/10ps

module fifo_overflow import sp_fetch_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic down,
	input  logic out_valid,
	input  logic out_ready,
	output logic down_safe
);

	fifo_count credits;       // Free FIFO slots not yet promised to a read
	fifo_count credits_next;
	logic      up;

	assign up = out_valid && out_ready;

	always_comb begin
		credits_next = credits;

		if (down && !up)
			credits_next = credits - 1'b1;
		else if (up && !down)
			credits_next = credits + 1'b1;
	end

	// Two credits leave room for a read that is raised on this same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= fifo_count'(fetch_fifo_depth);
			down_safe <= 1'b1;
		end else begin
			credits <= credits_next;
			down_safe <= credits_next >= fifo_count'(2);
		end
	end

endmodule

// File: verilog/sp_fetch.sv
`timescale 1ns/10ps

module sp_fetch import sp_fetch_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	insn_bus_if.master    bus,
	input  logic          program_start,
	input  vram_insn_addr program_header_base,
	input  cmd_word       program_header_size,
	output logic          running,
	input  logic          batch_end,
	output logic          batch_start,
	output vram_insn_addr batch_base,
	output cmd_word       batch_length,
	input  logic          ready,
	output logic          valid,
	output insn_word      insn,
	output logic          clear_lanes
);

	fetch_state    state;
	logic          insn_read;
	vram_insn_addr insn_address;
	logic          bus_accept;
	logic          bus_free;      // No request is held back by waitrequest
	logic          code_phase;
	logic          code_accept;
	logic          code_answer;

	cmd_word       header_count;  // Entries left, this one included
	vram_insn_addr header_ptr;
	entry_ptr      entry_fetch_count;
	entry_ptr      entry_read_count;
	logic          entry_end;
	logic          header_last;
	insn_word      entry_data [insn_entry_size];

	vram_insn_addr code_base;
	insn_word      code_length;
	insn_word      code_fetch_ptr;
	insn_word      code_read_ptr;
	fifo_count     inflight;
	logic          flush_done;

	fifo_entry     fifo_in;
	fifo_entry     fifo_out;
	logic          fifo_put;
	logic          fifo_empty;
	logic          fifo_down_safe;

	function automatic vram_insn_addr base_from_word(insn_word word);
		return word[insn_subword_bits +: $bits(vram_insn_addr)];
	endfunction

	assign bus.read = insn_read;
	assign bus.address = insn_address;
	assign bus_accept = insn_read && !bus.waitrequest;
	assign bus_free = !insn_read || !bus.waitrequest;

	assign code_phase = state == loop || state == flush;
	assign code_accept = bus_accept && code_phase;
	assign code_answer = bus.readdatavalid && code_phase;

	assign entry_end = entry_read_count == entry_ptr'(insn_entry_size - 1);
	assign header_last = header_count <= cmd_word'(1);
	assign code_base = base_from_word(entry_data[0]);
	assign code_length = entry_data[1];

	// Every code read answered and written, and the core has taken the last one
	assign flush_done = fifo_empty && !fifo_put && !insn_read && inflight == '0;

	assign insn = fifo_out[$bits(insn_word)-1:0];
	assign clear_lanes = fifo_out[$bits(insn_word)];

	insn_fifo fifo_i (
		.clk,
		.rst_n,
		.in(fifo_in),
		.in_valid(fifo_put),
		.out(fifo_out),
		.out_valid(valid),
		.out_ready(ready),
		.empty(fifo_empty)
	);

	fifo_overflow overflow_i (
		.clk,
		.rst_n,
		.down(code_accept),
		.out_valid(valid),
		.out_ready(ready),
		.down_safe(fifo_down_safe)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			running <= 1'b0;
			insn_read <= 1'b0;
			batch_start <= 1'b0;
			fifo_put <= 1'b0;
			inflight <= '0;
			entry_fetch_count <= '0;
			entry_read_count <= '0;
		end else begin
			batch_start <= 1'b0;
			fifo_put <= code_answer;

			case ({code_accept, code_answer})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: ;
			endcase

			unique case (state)
				idle: begin
					if (program_start && program_header_size != '0) begin
						state <= header;
						running <= 1'b1;
						insn_read <= 1'b1;
						entry_fetch_count <= '0;
						entry_read_count <= '0;
					end
				end

				header: begin
					if (bus_accept) begin
						entry_fetch_count <= entry_fetch_count + 1'b1;
						if (entry_fetch_count == entry_ptr'(insn_entry_size - 1))
							insn_read <= 1'b0;
					end

					if (bus.readdatavalid) begin
						entry_read_count <= entry_read_count + 1'b1;  // Wraps back to zero

						if (entry_end) begin
							state <= loop;
							insn_read <= 1'b1;
							batch_start <= 1'b1;
						end
					end
				end

				loop: begin
					if (bus_free)
						insn_read <= fifo_down_safe;

					// A held request stays up until taken, so its address is kept
					if (batch_end) begin
						state <= flush;
						if (bus_free)
							insn_read <= 1'b0;
					end
				end

				flush: begin
					if (bus_accept)
						insn_read <= 1'b0;

					if (flush_done) begin
						state <= header_last ? idle : header;
						running <= !header_last;
						insn_read <= !header_last;
					end
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Addresses, header entry and code pointers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		unique case (state)
			idle: begin
				if (program_start) begin
					header_ptr <= program_header_base;
					header_count <= program_header_size;
					insn_address <= program_header_base;
				end
			end

			header: begin
				if (bus_accept) begin
					insn_address <= insn_address + 1'b1;
					header_ptr <= header_ptr + 1'b1;
				end

				if (bus.readdatavalid) begin
					for (int i = 0; i < insn_entry_size - 1; i++)
						entry_data[i] <= entry_data[i + 1];
					entry_data[insn_entry_size - 1] <= bus.readdata;

					// Words are taken from their pre-shift slots
					if (entry_end) begin
						insn_address <= base_from_word(entry_data[1]);
						batch_base <= base_from_word(entry_data[3]);
						batch_length <= bus.readdata;
						code_fetch_ptr <= '0;
						code_read_ptr <= '0;
					end
				end
			end

			loop, flush: begin
				if (code_accept) begin
					if (code_fetch_ptr == code_length) begin
						insn_address <= code_base;
						code_fetch_ptr <= '0;
					end else begin
						insn_address <= insn_address + 1'b1;
						code_fetch_ptr <= code_fetch_ptr + 1'b1;
					end
				end

				if (code_answer) begin
					fifo_in <= {code_read_ptr == '0, bus.readdata};  // First word of a pass

					if (code_read_ptr == code_length)
						code_read_ptr <= '0;
					else
						code_read_ptr <= code_read_ptr + 1'b1;
				end

				if (state == flush && flush_done) begin
					header_count <= header_count - 1'b1;
					insn_address <= header_ptr;
				end
			end
		endcase
	end

endmodule

// File: verilog/sp_fetch_top.sv
`timescale 1ns/10ps

module sp_fetch_top import sp_fetch_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	output logic          fetch_read,
	output vram_addr      fetch_address,
	input  vram_word      fetch_readdata,
	input  logic          fetch_waitrequest,
	input  logic          fetch_readdatavalid,
	input  logic          program_start,
	input  vram_insn_addr program_header_base,
	input  cmd_word       program_header_size,
	output logic          running,
	input  logic          batch_end,
	output logic          batch_start,
	output vram_insn_addr batch_base,
	output cmd_word       batch_length,
	input  logic          ready,
	output logic          valid,
	output insn_word      insn,
	output logic          clear_lanes
);

	insn_bus_if insn_bus ();  // 32-bit instruction reads

	sp_fetch fetch_i (
		.clk,
		.rst_n,
		.bus(insn_bus.master),
		.program_start,
		.program_header_base,
		.program_header_size,
		.running,
		.batch_end,
		.batch_start,
		.batch_base,
		.batch_length,
		.ready,
		.valid,
		.insn,
		.clear_lanes
	);

	sp_widener widener_i (
		.clk,
		.rst_n,
		.bus(insn_bus.slave),
		.word_read(fetch_read),
		.word_address(fetch_address),
		.word_readdata(fetch_readdata),
		.word_waitrequest(fetch_waitrequest),
		.word_readdatavalid(fetch_readdatavalid)
	);

endmodule

// File: test/tb_sp_fetch.sv
`timescale 1ns/10ps

module tb_sp_fetch import sp_fetch_pkg::*; ();

	localparam int vram_words = 4096;
	localparam int max_tests = 16;
	localparam int max_batches = 64;
	localparam int cycles_per_test = 2000;

	logic          clk = 1'b0;
	logic          rst_n;
	logic          fetch_read;
	vram_addr      fetch_address;
	vram_word      fetch_readdata;
	logic          fetch_waitrequest;
	logic          fetch_readdatavalid;
	logic          program_start;
	vram_insn_addr program_header_base;
	cmd_word       program_header_size;
	logic          running;
	logic          batch_end;
	logic          batch_start;
	vram_insn_addr batch_base;
	cmd_word       batch_length;
	logic          ready;
	logic          valid;
	insn_word      insn;
	logic          clear_lanes;

	vram_word      vram [vram_words];
	int            test_count;
	vram_insn_addr test_header [max_tests];
	int            test_entries [max_tests];
	int            test_end_after [max_tests];  // Instructions received before batch_end
	int            test_random [max_tests];
	int            test_first_batch [max_tests];
	vram_insn_addr exp_base [max_batches];
	cmd_word       exp_length [max_batches];
	int            batch_lines;
	int            errors;
	int            failed_tests;
	int            current_test;
	logic          trace_loaded = 1'b0;

	always #20 clk = !clk;

	sp_fetch_top sp_fetch_top_i (.*);

	function automatic vram_word fill_word(int addr);
		return vram_word'(addr * 40503) ^ vram_word'(addr >> 4) ^ 16'h5a3c;
	endfunction

	// Instruction addresses count 32-bit words, low half at the even VRAM word
	function automatic insn_word read_insn(vram_insn_addr addr);
		int word;
		word = 2 * int'(addr);
		return {vram[(word + 1) % vram_words], vram[word % vram_words]};
	endfunction

	task automatic load_trace();
		int fd;
		int r;
		int c;
		int n;
		int e;
		int mode;
		byte tag;
		logic [31:0] a;
		logic [31:0] d;
		for (int i = 0; i < vram_words; i++)
			vram[i] = fill_word(i);
		test_count = 0;
		batch_lines = 0;
		fd = $fopen("test/sp_fetch_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file test/sp_fetch_trace.txt");
			errors++;
		end else begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				case (tag)
					"#": begin
						c = $fgetc(fd);
						while (c != "\n" && c != -1)
							c = $fgetc(fd);
					end
					"m": begin
						r = $fscanf(fd, " %h %h", a, d);
						if (r != 2) begin
							$display("The trace file holds an m line without address and data");
							errors++;
						end
						vram[2 * a] = d[15:0];
						vram[2 * a + 1] = d[31:16];
					end
					"t": begin
						r = $fscanf(fd, " %h %d %d %d", a, n, e, mode);
						if (r != 4) begin
							$display("The trace file holds a t line with missing fields");
							errors++;
						end
						test_header[test_count] = vram_insn_addr'(a);
						test_entries[test_count] = n;
						test_end_after[test_count] = e;
						test_random[test_count] = mode;
						test_first_batch[test_count] = batch_lines;
						test_count++;
					end
					"b": begin
						r = $fscanf(fd, " %h %h", a, d);
						if (r != 2) begin
							$display("The trace file holds a b line without base and length");
							errors++;
						end
						exp_base[batch_lines] = vram_insn_addr'(a);
						exp_length[batch_lines] = d;
						batch_lines++;
					end
					default: begin
						$display("The trace file holds a line of unknown type '%c'", tag);
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end
	endtask

	task automatic check_idle_outputs(string when);
		assert (!fetch_read && !running && !batch_start && !valid) else begin
			$display("FAIL %0t: outputs not idle %s (read %b running %b start %b valid %b)",
				$time, when, fetch_read, running, batch_start, valid);
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// VRAM model with random stalls and in-order answers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : vram_model
		int cycle;
		int due;
		int last_due;
		int due_q [$];
		vram_word data_q [$];
		vram_addr held_address;
		logic held;
		cycle = 0;
		last_due = 0;
		held = 1'b0;
		fetch_waitrequest = 1'b0;
		fetch_readdatavalid = 1'b0;
		fetch_readdata = '0;
		forever begin
			@(negedge clk);
			if (held)
				assert (fetch_read && fetch_address == held_address) else begin
					$display("FAIL %0t: VRAM request changed under waitrequest", $time);
					errors++;
				end
			held = fetch_read && fetch_waitrequest;
			held_address = fetch_address;
			if (fetch_read && !fetch_waitrequest) begin
				assert (fetch_address < vram_addr'(vram_words)) else begin
					$display("FAIL %0t: VRAM read at %h outside the image", $time, fetch_address);
					errors++;
				end
				due = cycle + 2 + int'($urandom % 4);  // One to four cycles after the accept
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
				data_q.push_back(vram[fetch_address % vram_words]);
			end
			@(posedge clk);
			cycle++;
			#2;
			fetch_waitrequest = ($urandom % 4) == 0;
			if (due_q.size() != 0 && due_q[0] == cycle) begin
				fetch_readdatavalid = 1'b1;
				fetch_readdata = data_q.pop_front();
				void'(due_q.pop_front());
			end else begin
				fetch_readdatavalid = 1'b0;
			end
		end
	end

	task automatic run_test(int t);
		int batch;
		int seen_batches;
		int received;          // Instructions of the current batch
		int total;
		int pass_len;
		int pos;
		int errors_before;
		logic started;
		logic done;
		logic end_sent;
		vram_insn_addr entry;
		vram_insn_addr code_base;
		insn_word word;
		insn_word expected;
		errors_before = errors;
		seen_batches = 0;
		received = 0;
		total = 0;
		pass_len = 1;
		code_base = '0;
		started = 1'b0;
		done = 1'b0;
		end_sent = 1'b1;
		@(posedge clk);
		#2;
		program_start = 1'b1;
		program_header_base = test_header[t];
		program_header_size = cmd_word'(test_entries[t]);
		do begin
			@(negedge clk);
			if (batch_start) begin
				batch = test_first_batch[t] + seen_batches;
				entry = test_header[t] + vram_insn_addr'(insn_entry_size * seen_batches);
				word = read_insn(entry);
				code_base = word[insn_subword_bits +: $bits(vram_insn_addr)];
				pass_len = int'(read_insn(entry + 1'b1)) + 1;
				assert (seen_batches < test_entries[t] && batch_base == exp_base[batch]
						&& batch_length == exp_length[batch]) else begin
					$display("FAIL %0t: test %0d batch %0d announced %h/%h, expected %h/%h",
						$time, t, seen_batches, batch_base, batch_length,
						exp_base[batch], exp_length[batch]);
					errors++;
				end
				seen_batches++;
				received = 0;
				end_sent = 1'b0;
			end
			if (valid && ready) begin
				pos = received % pass_len;
				expected = read_insn(code_base + vram_insn_addr'(pos));
				assert (seen_batches > 0 && insn == expected && clear_lanes == (pos == 0)) else begin
					$display("FAIL %0t: test %0d batch %0d insn %0d got %h/%b, expected %h/%b",
						$time, t, seen_batches, received, insn, clear_lanes, expected, pos == 0);
					errors++;
				end
				received++;
				total++;
			end
			done = started && !running;
			started = started || running;
			@(posedge clk);
			#2;
			program_start = 1'b0;
			batch_end = 1'b0;
			if (!end_sent && received >= test_end_after[t]) begin
				batch_end = 1'b1;
				end_sent = 1'b1;
			end
			// Sparse ready lets the FIFO fill up so the read credits run out
			ready = (test_random[t] != 0) ? (($urandom % 4) == 0) : 1'b1;
		end while (!done);

		assert (!fetch_read && !valid && seen_batches == test_entries[t]) else begin
			$display("FAIL %0t: test %0d ended with read %b valid %b after %0d of %0d batches",
				$time, t, fetch_read, valid, seen_batches, test_entries[t]);
			errors++;
		end
		if (errors != errors_before)
			failed_tests++;
		$display("Test %0d: %0d batches, %0d instructions, %s", t, seen_batches, total,
			(errors == errors_before) ? "ok" : "failed");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : main
		void'($urandom(20));
		errors = 0;
		failed_tests = 0;
		current_test = 0;
		rst_n = 1'b0;
		program_start = 1'b0;
		program_header_base = '0;
		program_header_size = '0;
		batch_end = 1'b0;
		ready = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_idle_outputs("during reset");
		end
		@(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs("after reset");
		for (int t = 0; t < test_count; t++) begin
			current_test = t;
			run_test(t);
		end
		$display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin : watchdog
		wait (trace_loaded);
		repeat (cycles_per_test * test_count + 10) @(posedge clk);
		$display("Timeout: test %0d did not finish within %0d cycles per test",
			current_test, cycles_per_test);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: test/sp_fetch_trace.txt
# m lines hold an instruction address and a 32-bit header word (low half at the even VRAM word)
# t lines hold header base, entries, insns before batch_end and ready mode (1 is random)
# Each t line is followed by one b line per entry with the expected batch base and length

# Program A with a six word loop, then a one word loop and a base with stray bits
m 100 00000400
m 101 00000005
m 102 00000600
m 103 00000040
m 104 00000480
m 105 00000000
m 106 ff000247
m 107 00001000

# Program B with a loop longer than the FIFO
m 180 00000500
m 181 00000002
m 182 00000020
m 183 00000007
m 184 00000580
m 185 0000000f
m 186 00000ffe
m 187 12345678
m 188 00000401
m 189 00000003
m 18a 00000002
m 18b 00000001

# Program C with one entry
m 1c0 00000600
m 1c1 00000006
m 1c2 00000800
m 1c3 00000099

t 100 2 20 0
b 300 00000040
b 123 00001000
t 180 3 9 1
b 010 00000007
b 7ff 12345678
b 001 00000001
t 1c0 1 40 1
b 400 00000099
t 100 2 13 1
b 300 00000040
b 123 00001000

// File: files.f
verilog/sp_fetch_pkg.sv
verilog/insn_bus_if.sv
verilog/sp_widener.sv
verilog/insn_fifo.sv
verilog/fifo_overflow.sv
verilog/sp_fetch.sv
verilog/sp_fetch_top.sv
test/tb_sp_fetch.sv

// File: Bender.yml
package:
  name: sp_fetch

sources:
  - verilog/sp_fetch_pkg.sv
  - verilog/insn_bus_if.sv
  - verilog/sp_widener.sv
  - verilog/insn_fifo.sv
  - verilog/fifo_overflow.sv
  - verilog/sp_fetch.sv
  - verilog/sp_fetch_top.sv
  - target: test
    files:
      - test/tb_sp_fetch.sv
